// File: dcache_pkg.sv
package dcache_pkg;

        localparam int WORD_W   = 32;
        localparam int NUM_SETS = 8;
        localparam int IDX_W    = 3;
        localparam int TAG_W    = 26;

        typedef logic [WORD_W-1:0] word_t;

        // Byte address split for lookup
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic             blkoff;
                logic [1:0]       bytoff;
        } daddr_f_t;

        typedef union packed {
                word_t    raw;
                daddr_f_t f;
        } daddr_u;

        typedef struct packed {
                logic             valid;
                logic             dirty;
                logic [TAG_W-1:0] tag;
                word_t [1:0]      data;
        } frame_t;

        typedef struct packed {
                logic   ren;
                logic   wen;
                logic   atomic;
                logic   halt;
                daddr_u addr;
                word_t  wdata;
        } cpu_req_t;

        typedef struct packed {
                logic  hit;
                word_t rdata;
                logic  flushed;
        } cpu_rsp_t;

        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t wdata;
        } mem_req_t;

        typedef enum logic [2:0] {
                LOOKUP,
                WB0,
                WB1,
                FILL0,
                FILL1,
                FLUSH_SCAN,
                FLUSH_WB0,
                FLUSH_WB1
        } ctrl_state_t;

endpackage

// File: cache_ways.sv
module cache_ways (
        input  logic                         CLK,
        input  logic                         nRST,
        input  logic [dcache_pkg::IDX_W-1:0] idx,
        input  logic [dcache_pkg::TAG_W-1:0] lookup_tag,
        input  logic                         wr_en,
        input  logic                         wr_way,
        input  logic                         wr_word,
        input  dcache_pkg::word_t            wr_data,
        input  logic                         fill_en,
        input  logic [dcache_pkg::TAG_W-1:0] fill_tag,
        input  logic                         set_valid,
        input  logic                         set_dirty,
        input  logic                         clear_state,
        input  logic                         lru_en,
        input  logic                         lru_way,
        output dcache_pkg::frame_t           frame0,
        output dcache_pkg::frame_t           frame1,
        output logic                         hit0,
        output logic                         hit1,
        output logic                         victim
);

        logic [1:0][dcache_pkg::NUM_SETS-1:0] valid_q;
        logic [1:0][dcache_pkg::NUM_SETS-1:0] dirty_q;
        logic [dcache_pkg::NUM_SETS-1:0]      lru_q;
        logic [dcache_pkg::TAG_W-1:0]         tag_q [2][dcache_pkg::NUM_SETS];
        dcache_pkg::word_t                    data_q [2][dcache_pkg::NUM_SETS][2];
        dcache_pkg::frame_t                   frm [2];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        valid_q <= '0;
                        dirty_q <= '0;
                        lru_q   <= '0;
                end else begin
                        // A new tag invalidates the frame until the fill ends
                        if (fill_en || clear_state) begin
                                valid_q[wr_way][idx] <= 1'b0;
                                dirty_q[wr_way][idx] <= 1'b0;
                        end
                        if (set_valid) begin
                                valid_q[wr_way][idx] <= 1'b1;
                        end
                        if (set_dirty) begin
                                dirty_q[wr_way][idx] <= 1'b1;
                        end
                        if (lru_en) begin
                                lru_q[idx] <= lru_way;
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (fill_en) begin
                        tag_q[wr_way][idx] <= fill_tag;
                end
                if (wr_en) begin
                        data_q[wr_way][idx][wr_word] <= wr_data;
                end
        end

        always_comb begin
                for (int w = 0; w < 2; w++) begin
                        frm[w].valid = valid_q[w][idx];
                        frm[w].dirty = dirty_q[w][idx];
                        frm[w].tag   = tag_q[w][idx];
                        frm[w].data  = {data_q[w][idx][1], data_q[w][idx][0]};
                end
        end

        assign frame0 = frm[0];
        assign frame1 = frm[1];
        assign hit0   = frame0.valid && (frame0.tag == lookup_tag);
        assign hit1   = frame1.valid && (frame1.tag == lookup_tag);

        // LRU bit holds the way used last
        assign victim = ~lru_q[idx];

        // One tag lives in at most one way of a set
        assert property (@(posedge CLK) disable iff (!nRST) !(hit0 && hit1));

endmodule

// File: link_reservation.sv
module link_reservation (
        input  logic              CLK,
        input  logic              nRST,
        input  logic              ll_set,
        input  logic              store,
        input  dcache_pkg::word_t addr,
        output logic              sc_ok
);

        dcache_pkg::word_t resv_addr;
        logic              resv_valid;

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        resv_valid <= 1'b0;
                end else if (ll_set) begin
                        resv_valid <= 1'b1;
                end else if (store && resv_valid && (addr == resv_addr)) begin
                        // Any store to the linked word breaks the link
                        resv_valid <= 1'b0;
                end
        end

        always_ff @(posedge CLK) begin
                if (ll_set) begin
                        resv_addr <= addr;
                end
        end

        assign sc_ok = resv_valid && (resv_addr == addr);

endmodule

// File: dcache_ctrl.sv
module dcache_ctrl (
        input  logic                         CLK,
        input  logic                         nRST,
        input  dcache_pkg::cpu_req_t         cpu_req,
        output dcache_pkg::cpu_rsp_t         cpu_rsp,
        output dcache_pkg::mem_req_t         mem_req,
        input  dcache_pkg::word_t            mem_rdata,
        input  logic                         mem_wait,
        output logic [dcache_pkg::IDX_W-1:0] idx,
        output logic [dcache_pkg::TAG_W-1:0] lookup_tag,
        output logic                         wr_en,
        output logic                         wr_way,
        output logic                         wr_word,
        output dcache_pkg::word_t            wr_data,
        output logic                         fill_en,
        output logic [dcache_pkg::TAG_W-1:0] fill_tag,
        output logic                         set_valid,
        output logic                         set_dirty,
        output logic                         clear_state,
        output logic                         lru_en,
        output logic                         lru_way,
        input  dcache_pkg::frame_t           frame0,
        input  dcache_pkg::frame_t           frame1,
        input  logic                         hit0,
        input  logic                         hit1,
        input  logic                         victim,
        output logic                         ll_set,
        output logic                         sc_store,
        input  logic                         sc_ok
);

        dcache_pkg::ctrl_state_t      state;
        dcache_pkg::ctrl_state_t      next_state;
        logic [dcache_pkg::IDX_W-1:0] flush_idx;
        logic                         sel_way;
        logic                         flush_done;
        dcache_pkg::frame_t           sel_frame;
        dcache_pkg::frame_t           hit_frame;
        dcache_pkg::daddr_u           blk_addr;
        logic                         in_lookup;
        logic                         flushing;
        logic                         word_sel;
        logic                         access;
        logic                         sc_fail;
        logic                         vic_dirty;
        logic                         set_clean;

        assign in_lookup = (state == dcache_pkg::LOOKUP);
        assign flushing  = state inside {dcache_pkg::FLUSH_SCAN, dcache_pkg::FLUSH_WB0,
                                         dcache_pkg::FLUSH_WB1};
        assign word_sel  = state inside {dcache_pkg::WB1, dcache_pkg::FILL1,
                                         dcache_pkg::FLUSH_WB1};
        assign access    = cpu_req.ren || cpu_req.wen;
        assign sc_fail   = cpu_req.atomic && cpu_req.wen && !sc_ok;
        assign vic_dirty = victim ? frame1.dirty : frame0.dirty;
        assign set_clean = !frame0.dirty && !frame1.dirty;
        assign sel_frame = sel_way ? frame1 : frame0;
        assign hit_frame = hit1 ? frame1 : frame0;

        assign idx        = flushing ? flush_idx : cpu_req.addr.f.idx;
        assign lookup_tag = cpu_req.addr.f.tag;
        assign fill_tag   = cpu_req.addr.f.tag;
        assign wr_way     = in_lookup ? hit1 : sel_way;
        assign wr_word    = in_lookup ? cpu_req.addr.f.blkoff : word_sel;
        assign wr_data    = in_lookup ? cpu_req.wdata : mem_rdata;
        assign lru_way    = hit1;

        // Block address of the current memory word
        always_comb begin
                blk_addr.f.tag    = flushing || state inside {dcache_pkg::WB0, dcache_pkg::WB1}
                                    ? sel_frame.tag : cpu_req.addr.f.tag;
                blk_addr.f.idx    = idx;
                blk_addr.f.blkoff = word_sel;
                blk_addr.f.bytoff = 2'b00;
        end

        always_comb begin
                mem_req = '0;
                case (state)
                        dcache_pkg::WB0, dcache_pkg::WB1,
                        dcache_pkg::FLUSH_WB0, dcache_pkg::FLUSH_WB1: begin
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = blk_addr.raw;
                                mem_req.wdata = sel_frame.data[word_sel];
                        end
                        dcache_pkg::FILL0, dcache_pkg::FILL1: begin
                                mem_req.ren  = 1'b1;
                                mem_req.addr = blk_addr.raw;
                        end
                        default: ;
                endcase
        end

        always_comb begin
                next_state      = state;
                cpu_rsp.hit     = 1'b0;
                cpu_rsp.rdata   = '0;
                cpu_rsp.flushed = flush_done;
                wr_en           = 1'b0;
                fill_en         = 1'b0;
                set_valid       = 1'b0;
                set_dirty       = 1'b0;
                clear_state     = 1'b0;
                lru_en          = 1'b0;
                ll_set          = 1'b0;
                sc_store        = 1'b0;
                case (state)
                        dcache_pkg::LOOKUP: begin
                                if (cpu_req.halt) begin
                                        next_state = dcache_pkg::FLUSH_SCAN;
                                end else if (sc_fail) begin
                                        // Failed SC answers 0 and leaves the cache alone
                                        cpu_rsp.hit = 1'b1;
                                end else if (access && (hit0 || hit1)) begin
                                        cpu_rsp.hit = 1'b1;
                                        lru_en      = 1'b1;
                                        if (cpu_req.wen) begin
                                                wr_en         = 1'b1;
                                                set_dirty     = 1'b1;
                                                sc_store      = 1'b1;
                                                cpu_rsp.rdata = dcache_pkg::word_t'(cpu_req.atomic);
                                        end else begin
                                                cpu_rsp.rdata = hit_frame.data[cpu_req.addr.f.blkoff];
                                                ll_set        = cpu_req.atomic;
                                        end
                                end else if (access) begin
                                        next_state = vic_dirty ? dcache_pkg::WB0 : dcache_pkg::FILL0;
                                end
                        end
                        dcache_pkg::WB0: begin
                                if (!mem_wait) next_state = dcache_pkg::WB1;
                        end
                        dcache_pkg::WB1: begin
                                if (!mem_wait) next_state = dcache_pkg::FILL0;
                        end
                        dcache_pkg::FILL0: begin
                                if (!mem_wait) begin
                                        wr_en      = 1'b1;
                                        fill_en    = 1'b1;
                                        next_state = dcache_pkg::FILL1;
                                end
                        end
                        dcache_pkg::FILL1: begin
                                if (!mem_wait) begin
                                        wr_en      = 1'b1;
                                        set_valid  = 1'b1;
                                        next_state = dcache_pkg::LOOKUP;
                                end
                        end
                        dcache_pkg::FLUSH_SCAN: begin
                                if (!cpu_req.halt) begin
                                        next_state = dcache_pkg::LOOKUP;
                                end else if (!set_clean) begin
                                        next_state = dcache_pkg::FLUSH_WB0;
                                end
                        end
                        dcache_pkg::FLUSH_WB0: begin
                                if (!mem_wait) next_state = dcache_pkg::FLUSH_WB1;
                        end
                        dcache_pkg::FLUSH_WB1: begin
                                // Rescan the same set for the other way
                                if (!mem_wait) begin
                                        clear_state = 1'b1;
                                        next_state  = dcache_pkg::FLUSH_SCAN;
                                end
                        end
                        default: next_state = dcache_pkg::LOOKUP;
                endcase
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state      <= dcache_pkg::LOOKUP;
                        sel_way    <= 1'b0;
                        flush_idx  <= '0;
                        flush_done <= 1'b0;
                end else begin
                        state <= next_state;
                        if (in_lookup) begin
                                sel_way    <= victim;
                                flush_idx  <= '0;
                                flush_done <= 1'b0;
                        end else if (state == dcache_pkg::FLUSH_SCAN) begin
                                sel_way <= !frame0.dirty;
                                if (set_clean) begin
                                        if (flush_idx == dcache_pkg::NUM_SETS - 1) begin
                                                flush_done <= 1'b1;
                                        end else begin
                                                flush_idx <= flush_idx + 1'b1;
                                        end
                                end
                        end
                end
        end

        assert property (@(posedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen));

        // Held request must not move until memory completes it
        assert property (@(posedge CLK) disable iff (!nRST)
                (mem_req.ren || mem_req.wen) && mem_wait |=> $stable(mem_req));

endmodule

// File: dcache_top.sv
module dcache_top (
        input  logic                 CLK,
        input  logic                 nRST,
        input  dcache_pkg::cpu_req_t cpu_req,
        output dcache_pkg::cpu_rsp_t cpu_rsp,
        output dcache_pkg::mem_req_t mem_req,
        input  dcache_pkg::word_t    mem_rdata,
        input  logic                 mem_wait
);

        logic [dcache_pkg::IDX_W-1:0] idx;
        logic [dcache_pkg::TAG_W-1:0] lookup_tag;
        logic [dcache_pkg::TAG_W-1:0] fill_tag;
        logic                         wr_en;
        logic                         wr_way;
        logic                         wr_word;
        dcache_pkg::word_t            wr_data;
        logic                         fill_en;
        logic                         set_valid;
        logic                         set_dirty;
        logic                         clear_state;
        logic                         lru_en;
        logic                         lru_way;
        dcache_pkg::frame_t           frame0;
        dcache_pkg::frame_t           frame1;
        logic                         hit0;
        logic                         hit1;
        logic                         victim;
        logic                         ll_set;
        logic                         sc_store;
        logic                         sc_ok;

        dcache_ctrl u_ctrl (.*);

        cache_ways u_ways (.*);

        link_reservation u_resv (
                .CLK   (CLK),
                .nRST  (nRST),
                .ll_set(ll_set),
                .store (sc_store),
                .addr  (cpu_req.addr.raw),
                .sc_ok (sc_ok)
        );

endmodule

// File: tb_mem_model.sv
module tb_mem_model (
        input  logic                 CLK,
        input  logic                 nRST,
        input  dcache_pkg::mem_req_t req,
        output dcache_pkg::word_t    rdata,
        output logic                 mem_wait
);
        timeunit 1ns;
        timeprecision 100ps;

        localparam int DEPTH = 256;

        dcache_pkg::word_t mem [DEPTH];
        logic [1:0]        wait_cnt;
        logic [7:0]        widx;
        logic              active;

        // Every bit of the byte address shapes the word
        function automatic dcache_pkg::word_t fill_word(input int i);
                dcache_pkg::word_t a;
                a = dcache_pkg::word_t'(i) << 2;
                return (a * 32'h9E3779B1) ^ 32'h5A5A5A5A;
        endfunction

        assign active   = req.ren || req.wen;
        assign widx     = req.addr[9:2];
        assign mem_wait = active && (wait_cnt != 2'd0);
        assign rdata    = req.ren ? mem[widx] : '0;

        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                mem[i] <= fill_word(i);
                        end
                        wait_cnt <= 2'd0;
                end else if (active) begin
                        if (wait_cnt != 2'd0) begin
                                wait_cnt <= wait_cnt - 2'd1;
                        end else begin
                                // Word completes here and the next stall is drawn
                                if (req.wen) begin
                                        mem[widx] <= req.wdata;
                                end
                                wait_cnt <= 2'($urandom_range(3, 0));
                        end
                end
        end

endmodule

// File: tb_dcache.sv
module tb_dcache;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int TIMEOUT   = 200;
        localparam int MEM_WORDS = 256;

        logic                 CLK;
        logic                 nRST;
        dcache_pkg::cpu_req_t cpu_req;
        dcache_pkg::cpu_rsp_t cpu_rsp;
        dcache_pkg::mem_req_t mem_req;
        dcache_pkg::word_t    mem_rdata;
        logic                 mem_wait;

        dcache_pkg::word_t    shadow [MEM_WORDS];
        dcache_pkg::word_t    watch_blk;
        logic                 expect_hit;
        logic                 sc_expect;
        int                   wb_seen = 0;
        int                   errors = 0;
        int                   timeouts = 0;

        dcache_top DUT (.*);

        tb_mem_model u_mem (
                .CLK     (CLK),
                .nRST    (nRST),
                .req     (mem_req),
                .rdata   (mem_rdata),
                .mem_wait(mem_wait)
        );

        initial begin
                CLK = 1'b0;
                forever #4 CLK = ~CLK;
        end

        // Shadow starts as a copy of memory and follows completed stores
        always @(negedge CLK) begin
                if (!nRST) begin
                        for (int i = 0; i < MEM_WORDS; i++) begin
                                shadow[i] <= u_mem.mem[i];
                        end
                end else if (cpu_rsp.hit && cpu_req.wen && (!cpu_req.atomic || sc_expect)) begin
                        shadow[cpu_req.addr.raw[9:2]] <= cpu_req.wdata;
                end
        end

        always @(negedge CLK) begin
                if (mem_req.wen && !mem_wait && (mem_req.addr[31:3] == watch_blk[31:3])) begin
                        wb_seen <= wb_seen + 1;
                end
        end

        assert property (@(negedge CLK) disable iff (!nRST)
                cpu_rsp.hit && cpu_req.ren |-> cpu_rsp.rdata == shadow[cpu_req.addr.raw[9:2]])
        else begin
                errors++;
                $display("[ERROR] cpu_rsp.rdata at %h got %h expected %h", cpu_req.addr.raw,
                         cpu_rsp.rdata, shadow[cpu_req.addr.raw[9:2]]);
        end

        assert property (@(negedge CLK) disable iff (!nRST)
                cpu_rsp.hit && cpu_req.wen && cpu_req.atomic |->
                cpu_rsp.rdata == dcache_pkg::word_t'(sc_expect))
        else begin
                errors++;
                $display("[ERROR] cpu_rsp.rdata for SC at %h got %h expected %h",
                         cpu_req.addr.raw, cpu_rsp.rdata, dcache_pkg::word_t'(sc_expect));
        end

        assert property (@(negedge CLK) disable iff (!nRST) expect_hit |-> cpu_rsp.hit)
        else begin
                errors++;
                $display("Repeated read of %h missed in its request cycle", cpu_req.addr.raw);
        end

        // Written back words must hold the latest stored values
        assert property (@(negedge CLK) disable iff (!nRST)
                mem_req.wen && !mem_wait |-> mem_req.wdata == shadow[mem_req.addr[9:2]])
        else begin
                errors++;
                $display("[ERROR] mem_req.wdata at %h got %h expected %h", mem_req.addr,
                         mem_req.wdata, shadow[mem_req.addr[9:2]]);
        end

        assert property (@(negedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen))
        else begin
                errors++;
                $display("Memory read and write requested together at %h", mem_req.addr);
        end

        assert property (@(negedge CLK) disable iff (!nRST)
                (mem_req.ren || mem_req.wen) && mem_wait |=> $stable(mem_req))
        else begin
                errors++;
                $display("Memory request changed while mem_wait was high");
        end

        assert property (@(negedge CLK) disable iff (!nRST)
                cpu_rsp.flushed && cpu_req.halt |=> cpu_rsp.flushed)
        else begin
                errors++;
                $display("Flushed flag dropped while halt was held");
        end

        function automatic dcache_pkg::word_t mk_addr(input int tag, input int set, input int off);
                return dcache_pkg::word_t'((tag << 6) | (set << 3) | (off << 2));
        endfunction

        task automatic finish_run();
                $display("errors: %0d  timeouts: %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        endtask

        // One processor request held until hit
        task automatic access(input logic rd, input logic wr, input logic at,
                              input dcache_pkg::word_t a, input dcache_pkg::word_t d,
                              input logic first_hit);
                logic done;
                done           = 1'b0;
                cpu_req.ren    = rd;
                cpu_req.wen    = wr;
                cpu_req.atomic = at;
                cpu_req.addr   = a;
                cpu_req.wdata  = d;
                expect_hit     = first_hit;
                for (int t = 0; t < TIMEOUT && !done; t++) begin
                        @(negedge CLK);
                        done = cpu_rsp.hit;
                        @(posedge CLK);
                        #1;
                        expect_hit = 1'b0;
                end
                cpu_req = '0;
                if (!done) begin
                        $display("Timeout waiting for hit on request to %h", a);
                        timeouts++;
                        finish_run();
                end
        endtask

        task automatic wait_flushed();
                logic done;
                done = 1'b0;
                for (int t = 0; t < 10 * TIMEOUT && !done; t++) begin
                        @(negedge CLK);
                        done = cpu_rsp.flushed;
                end
                if (!done) begin
                        $display("Timeout waiting for flushed after halt");
                        timeouts++;
                        finish_run();
                end
        endtask

        initial begin
                dcache_pkg::word_t a;
                int                base;
                void'($urandom(55));
                nRST       = 1'b0;
                cpu_req    = '0;
                expect_hit = 1'b0;
                sc_expect  = 1'b0;
                watch_blk  = '0;
                repeat (2) @(posedge CLK);
                #1;
                nRST = 1'b1;

                // Three tags in set 5 leave tag 2 least recently used
                access(1'b0, 1'b1, 1'b0, mk_addr(1, 5, 0), $urandom, 1'b0);
                access(1'b0, 1'b1, 1'b0, mk_addr(2, 5, 1), $urandom, 1'b0);
                access(1'b1, 1'b0, 1'b0, mk_addr(1, 5, 1), '0, 1'b0);
                watch_blk = mk_addr(2, 5, 0);
                base      = wb_seen;
                access(1'b0, 1'b1, 1'b0, mk_addr(3, 5, 0), $urandom, 1'b0);
                assert (wb_seen - base == 2)
                else begin
                        errors++;
                        $display("Least recently used block was not written back as two words");
                end

                for (int n = 0; n < 80; n++) begin
                        a = mk_addr($urandom_range(15, 0), $urandom_range(7, 0),
                                    $urandom_range(1, 0));
                        if ($urandom_range(1, 0) == 1) begin
                                access(1'b1, 1'b0, 1'b0, a, '0, 1'b0);
                                access(1'b1, 1'b0, 1'b0, a, '0, 1'b1);
                        end else begin
                                access(1'b0, 1'b1, 1'b0, a, $urandom, 1'b0);
                        end
                end

                a         = mk_addr(7, 2, 1);
                sc_expect = 1'b1;
                access(1'b1, 1'b0, 1'b1, a, '0, 1'b0);
                access(1'b0, 1'b1, 1'b1, a, $urandom, 1'b0);
                // Reservation is gone after the successful SC
                sc_expect = 1'b0;
                access(1'b0, 1'b1, 1'b1, a, $urandom, 1'b0);
                access(1'b1, 1'b0, 1'b1, a, '0, 1'b0);
                access(1'b0, 1'b1, 1'b0, a, $urandom, 1'b0);
                access(1'b0, 1'b1, 1'b1, a, $urandom, 1'b0);
                access(1'b1, 1'b0, 1'b0, a, '0, 1'b0);

                cpu_req.halt = 1'b1;
                wait_flushed();
                repeat (3) @(negedge CLK);
                for (int i = 0; i < MEM_WORDS; i++) begin
                        assert (u_mem.mem[i] == shadow[i])
                        else begin
                                errors++;
                                $display("[ERROR] mem[%h] got %h expected %h", i * 4,
                                         u_mem.mem[i], shadow[i]);
                        end
                end
                @(posedge CLK);
                #1;
                cpu_req.halt = 1'b0;
                repeat (2) @(posedge CLK);
                finish_run();
        end

endmodule

// File: sim.f
dcache_pkg.sv
cache_ways.sv
link_reservation.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_dcache
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
